// File: fetch_cfg.svh
/* Address, instruction cache geometry, memory bus and reset instruction macros */

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////////////////////////
// Address and instruction widths
////////////////////////////////////////
`define FETCH_ADDR_W 32                     // Fetch and bus address
`define INST_W       32

////////////////////////////////////////
// Instruction cache geometry
////////////////////////////////////////
`define ICACHE_LINES 128
`define ICACHE_IDX_W 7
`define ICACHE_OFS_W 3                      // Byte offset inside one 64-bit line
`define ICACHE_TAG_W (`FETCH_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

////////////////////////////////////////
// Memory bus
////////////////////////////////////////
`define MEM_DATA_W 64
`define MEM_TAG_W  4                        // Zero response means refused

`define BUS_NONE 2'b00
`define BUS_LOAD 2'b01

// Alpha-style noop held in the IF/ID register out of reset
`define NOOP_INST 32'h47ff041f

`endif

// File: fetch_pkg.sv
/* Fetch address union, memory bus request and response structs, fetch packet */

`include "fetch_cfg.svh"

package fetch_pkg;

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  // Cache view of an address
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [`ICACHE_IDX_W-1:0] index;
    logic [`ICACHE_OFS_W-1:0] offset;
  } fetch_addr_fields_t;

  // PC and bus read raw, cache reads the fields
  typedef union packed {
    logic [`FETCH_ADDR_W-1:0] raw;
    fetch_addr_fields_t       f;
  } fetch_addr_u;

  ////////////////////////////////////////
  // Memory bus and fetch output
  ////////////////////////////////////////
  typedef struct packed {
    logic [1:0]               command;      // BUS_NONE or BUS_LOAD
    logic [`FETCH_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_TAG_W-1:0]  response;       // Tag given to an accepted request
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_TAG_W-1:0]  tag;            // Tag of the reply carried in data
  } mem_resp_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] npc;
    logic [`INST_W-1:0]       ir;
    logic                     valid;
  } fetch_packet_t;

endpackage

// File: icache_mem.sv
/* Direct-mapped instruction cache storage with data, tag and valid arrays */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_mem (
  input  logic                     clk,
  input  logic                     reset,

  // Line fill
  input  logic                     wr_en,
  input  logic [`ICACHE_IDX_W-1:0] wr_idx,
  input  logic [`ICACHE_TAG_W-1:0] wr_tag,
  input  logic [`MEM_DATA_W-1:0]   wr_data,

  // Lookup
  input  logic [`ICACHE_IDX_W-1:0] rd_idx,
  input  logic [`ICACHE_TAG_W-1:0] rd_tag,
  output logic [`MEM_DATA_W-1:0]   rd_data,
  output logic                     rd_valid
);

  logic [`MEM_DATA_W-1:0]   data_ram [`ICACHE_LINES];
  logic [`ICACHE_TAG_W-1:0] tag_ram  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Every line starts empty
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_ram[wr_idx] <= wr_data;
      tag_ram[wr_idx]  <= wr_tag;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////
  assign rd_data  = data_ram[rd_idx];
  assign rd_valid = valid_q[rd_idx] && (tag_ram[rd_idx] == rd_tag);   // Hit

endmodule

// File: icache_ctrl.sv
/* Instruction cache controller with miss detection, bus request, outstanding
   tag tracking and line fill */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_ctrl (
  input  logic                     clk,
  input  logic                     reset,

  // Fetch side
  input  fetch_pkg::fetch_addr_u   fetch_addr,
  output logic [`MEM_DATA_W-1:0]   hit_data,
  output logic                     hit,

  // Memory bus
  input  fetch_pkg::mem_resp_t     mem_resp,
  output fetch_pkg::mem_req_t      mem_req,

  // Cache memory lookup
  output logic [`ICACHE_IDX_W-1:0] rd_idx,
  output logic [`ICACHE_TAG_W-1:0] rd_tag,
  input  logic [`MEM_DATA_W-1:0]   rd_data,
  input  logic                     rd_valid,

  // Cache memory fill
  output logic                     wr_en,
  output logic [`ICACHE_IDX_W-1:0] wr_idx,
  output logic [`ICACHE_TAG_W-1:0] wr_tag,
  output logic [`MEM_DATA_W-1:0]   wr_data
);

  localparam logic [1:0] ST_IDLE = 2'd0;    // Nothing outstanding
  localparam logic [1:0] ST_REQ  = 2'd1;    // Load on the bus, waiting for acceptance
  localparam logic [1:0] ST_WAIT = 2'd2;    // Accepted, waiting for the tagged reply

  logic [1:0]              state_q;
  logic [1:0]              state_nxt;
  logic                    start;
  logic                    accept;
  logic                    fill;
  fetch_pkg::fetch_addr_u  line_q;          // Line being fetched, offset zero
  logic [`MEM_TAG_W-1:0]   out_tag_q;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////
  assign rd_idx   = fetch_addr.f.index;
  assign rd_tag   = fetch_addr.f.tag;
  assign hit      = rd_valid;
  assign hit_data = rd_data;

  ////////////////////////////////////////
  // Miss handling FSM
  ////////////////////////////////////////
  assign start  = (state_q == ST_IDLE) && !rd_valid;
  assign accept = (state_q == ST_REQ) && (mem_resp.response != '0);
  assign fill   = (state_q == ST_WAIT) && (mem_resp.tag == out_tag_q);

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_REQ;
        end
      end
      ST_REQ: begin
        if (accept) begin               // Refused requests simply repeat
          state_nxt = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (fill) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // Missed line latched when the request starts
  always_ff @(posedge clk) begin
    if (start) begin
      line_q.f.tag    <= fetch_addr.f.tag;
      line_q.f.index  <= fetch_addr.f.index;
      line_q.f.offset <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_tag_q <= mem_resp.response;
    end
  end

  ////////////////////////////////////////
  // Bus request and fill
  ////////////////////////////////////////
  always_comb begin
    mem_req.command = (state_q == ST_REQ) ? `BUS_LOAD : `BUS_NONE;
    mem_req.addr    = line_q.raw;
  end

  // Old line still fills if the PC has moved on
  assign wr_en   = fill;
  assign wr_idx  = line_q.f.index;
  assign wr_tag  = line_q.f.tag;
  assign wr_data = mem_resp.data;

endmodule

// File: fetch_stage.sv
/* Program counter with redirect, instruction half select and the IF/ID
   output register */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall,        // Hazard stall from the back end
  input  logic                     redirect,     // Mispredict pulse
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,

  // Cache controller
  input  logic                     hit,
  input  logic [`MEM_DATA_W-1:0]   hit_data,
  output fetch_pkg::fetch_addr_u   fetch_addr,

  // IF/ID register
  output fetch_pkg::fetch_packet_t fetch_out
);

  fetch_pkg::fetch_addr_u   pc_q;
  logic [`FETCH_ADDR_W-1:0] pc_plus4;
  logic [`INST_W-1:0]       inst;
  logic                     advance;

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////
  assign fetch_addr = pc_q;
  assign pc_plus4   = pc_q.raw + `FETCH_ADDR_W'(4);
  assign advance    = hit && !stall;    // Sit on a miss until the fill lands

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q.raw <= '0;
    end else if (redirect) begin        // Redirect beats stall
      pc_q.raw <= redirect_pc;
    end else if (advance) begin
      pc_q.raw <= pc_plus4;
    end
  end

  ////////////////////////////////////////
  // Instruction select
  ////////////////////////////////////////

  // Offset bit 2 picks the upper word of the line
  assign inst = pc_q.f.offset[`ICACHE_OFS_W-1] ? hit_data[`MEM_DATA_W-1:`INST_W]
                                               : hit_data[`INST_W-1:0];

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_out.npc   <= '0;
      fetch_out.ir    <= `NOOP_INST;
      fetch_out.valid <= 1'b0;
    end else if (redirect) begin
      fetch_out.valid <= 1'b0;          // Squash whatever was in flight
    end else if (!stall) begin
      fetch_out.npc   <= pc_plus4;
      fetch_out.ir    <= inst;
      fetch_out.valid <= hit;
    end
  end

endmodule

// File: fetch_top.sv
/* Fetch front end top with fetch stage, cache controller and cache memory */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall,
  input  logic                     redirect,
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
  input  fetch_pkg::mem_resp_t     mem_resp,
  output fetch_pkg::mem_req_t      mem_req,
  output fetch_pkg::fetch_packet_t fetch_out
);

  fetch_pkg::fetch_addr_u   fetch_addr;
  logic                     hit;
  logic [`MEM_DATA_W-1:0]   hit_data;

  // Cache memory ports
  logic [`ICACHE_IDX_W-1:0] rd_idx;
  logic [`ICACHE_TAG_W-1:0] rd_tag;
  logic [`MEM_DATA_W-1:0]   rd_data;
  logic                     rd_valid;
  logic                     wr_en;
  logic [`ICACHE_IDX_W-1:0] wr_idx;
  logic [`ICACHE_TAG_W-1:0] wr_tag;
  logic [`MEM_DATA_W-1:0]   wr_data;

  fetch_stage u_fetch_stage (
    .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .hit(hit), .hit_data(hit_data),
    .fetch_addr(fetch_addr), .fetch_out(fetch_out)
  );

  icache_ctrl u_icache_ctrl (
    .clk(clk), .reset(reset), .fetch_addr(fetch_addr),
    .hit_data(hit_data), .hit(hit), .mem_resp(mem_resp), .mem_req(mem_req),
    .rd_idx(rd_idx), .rd_tag(rd_tag), .rd_data(rd_data), .rd_valid(rd_valid),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_tag(wr_tag), .wr_data(wr_data)
  );

  icache_mem u_icache_mem (
    .clk(clk), .reset(reset), .wr_en(wr_en), .wr_idx(wr_idx),
    .wr_tag(wr_tag), .wr_data(wr_data), .rd_idx(rd_idx), .rd_tag(rd_tag),
    .rd_data(rd_data), .rd_valid(rd_valid)
  );

endmodule

// File: fetch_tb_clk.sv
/* Testbench clock and reset generator */

`timescale 1ns/1ps

module fetch_tb_clk (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;             // 20 ns period
  end

  // Reset held for the first 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: fetch_assert.sv
/* Concurrent assertions on the memory bus and the IF/ID register, bound to the
   fetch top level */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_assert (
  input logic                     clk,
  input logic                     reset,
  input logic                     stall,
  input logic                     redirect,
  input fetch_pkg::mem_req_t      mem_req,
  input fetch_pkg::fetch_packet_t fetch_out
);

  // Only two bus commands exist
  assert property (@(posedge clk) disable iff (reset)
    (mem_req.command == `BUS_NONE) || (mem_req.command == `BUS_LOAD))
    else $error("illegal bus command %b", mem_req.command);

  assert property (@(posedge clk) reset |=> !fetch_out.valid)
    else $error("fetch output valid right after reset");

  // IF/ID register holds under stall
  assert property (@(posedge clk) disable iff (reset)
    (stall && !redirect) |=> $stable(fetch_out))
    else $error("fetch output changed on a stalled edge");

  assert property (@(posedge clk) disable iff (reset)
    (mem_req.command == `BUS_LOAD) |-> (mem_req.addr[`ICACHE_OFS_W-1:0] == '0))
    else $error("load address %h not line aligned", mem_req.addr);

endmodule

bind fetch_top fetch_assert u_fetch_assert (
  .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
  .mem_req(mem_req), .fetch_out(fetch_out)
);

// File: fetch_tb.sv
/* Fetch front end testbench with memory model, stimulus, reference model,
   output comparison and watchdog */

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

  localparam int EXPECTED_FETCHES = 400;
  localparam int CYCLES_PER_FETCH = 40;
  localparam int CLK_PERIOD_NS    = 20;

  logic                     clk;
  logic                     reset;
  logic                     stall;
  logic                     redirect;
  logic [`FETCH_ADDR_W-1:0] redirect_pc;
  fetch_pkg::mem_resp_t     mem_resp;
  fetch_pkg::mem_req_t      mem_req;
  fetch_pkg::fetch_packet_t fetch_out;

  int  error_count;
  int  check_count;
  int  out_count;
  int  wait_target;
  int  test_errors;
  int  test_num;
  bit  refetch_check;                   // Filled lines must not go to memory

  fetch_tb_clk u_clk (.clk(clk), .reset(reset));

  fetch_top u_dut (
    .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .mem_resp(mem_resp), .mem_req(mem_req),
    .fetch_out(fetch_out)
  );

  ////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////

  // Instruction word at a word-aligned address
  function automatic logic [31:0] ref_inst(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h1f2e3d4c;
    x = x * 32'h01000193;
    return x ^ (x >> 13);
  endfunction

  function automatic logic [63:0] ref_line(input logic [31:0] addr);
    return {ref_inst({addr[31:3], 3'b100}), ref_inst({addr[31:3], 3'b000})};
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////
  initial begin
    bit          busy;
    int          delay;
    logic [3:0]  pend_tag;
    logic [31:0] pend_addr;
    busy     = 1'b0;
    mem_resp = '0;
    forever begin
      @(posedge clk);
      if (reset) begin
        busy     = 1'b0;
        mem_resp <= '0;
      end else begin
        mem_resp.tag <= '0;             // Reply lasts one cycle
        if (busy) begin
          if (delay == 0) begin
            mem_resp.tag  <= pend_tag;
            mem_resp.data <= ref_line(pend_addr);
            busy = 1'b0;
          end else begin
            delay--;
          end
        end
        if (mem_req.command == `BUS_LOAD && mem_resp.response != '0) begin
          if (busy) begin
            error_count++;
            $display("Second load issued while one was still outstanding at %0t ns", $time);
          end
          busy      = 1'b1;
          pend_tag  = mem_resp.response;
          pend_addr = mem_req.addr;
          delay     = $urandom % 8;
        end
        // Offer a tag every cycle, refuse one time in four
        if ($urandom % 4 == 0) begin
          mem_resp.response <= '0;
        end else begin
          mem_resp.response <= 4'(1 + $urandom % 15);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////
  initial begin
    logic [31:0]              exp_pc;
    bit                       loaded;
    bit                       held;
    bit                       squashed;
    fetch_pkg::fetch_packet_t last_out;
    exp_pc   = '0;
    loaded   = 1'b0;
    held     = 1'b0;
    squashed = 1'b0;
    forever begin
      @(posedge clk);
      if (reset) begin
        exp_pc   = '0;
        loaded   = 1'b0;
        held     = 1'b0;
        squashed = 1'b0;
      end else begin
        // A new output only if the last edge loaded the register
        if (loaded && fetch_out.valid) begin
          check_value("fetch_out.npc", fetch_out.npc, exp_pc + 32'd4);
          check_value("fetch_out.ir", fetch_out.ir, ref_inst(exp_pc));
          exp_pc = exp_pc + 32'd4;
          out_count++;
        end
        if (squashed) begin
          check_value("fetch_out.valid after redirect", fetch_out.valid, 1'b0);
        end
        if (held) begin
          check_value("held fetch_out", fetch_out, last_out);
        end
        if (refetch_check && mem_req.command == `BUS_LOAD && mem_req.addr < 32'd256) begin
          check_value("mem_req.command on filled line", mem_req.command, `BUS_NONE);
        end
        if (redirect) begin
          exp_pc = redirect_pc;
        end
        loaded   = !redirect && !stall;
        held     = stall && !redirect;
        squashed = redirect;
        last_out = fetch_out;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic wait_outputs(input int n);
    wait_target = out_count + n;
    while (out_count < wait_target) @(posedge clk);
  endtask

  task automatic apply_redirect(input logic [31:0] target);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s: %s (%0d errors)", test_num, name,
             (error_count == test_errors) ? "ok" : "FAILED", error_count - test_errors);
    test_errors = error_count;
  endtask

  initial begin
    stall         = 1'b0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    error_count   = 0;
    check_count   = 0;
    out_count     = 0;
    wait_target   = 0;
    test_errors   = 0;
    test_num      = 0;
    refetch_check = 1'b0;
    void'($urandom(47361));

    // Reset values
    @(posedge clk);
    while (reset) @(posedge clk);
    check_value("mem_req.command", mem_req.command, `BUS_NONE);
    check_value("fetch_out.valid", fetch_out.valid, 1'b0);
    check_value("fetch_out.ir", fetch_out.ir, `NOOP_INST);
    end_test("reset state");

    wait_outputs(64);                   // Cold misses from address 0
    end_test("sequential fetch");

    apply_redirect(32'd0);
    refetch_check = 1'b1;
    wait_outputs(48);
    refetch_check = 1'b0;
    end_test("refetch of filled lines");

    wait_target = out_count + 64;
    while (out_count < wait_target) begin
      @(posedge clk);
      stall <= ($urandom % 3 == 0);
    end
    @(posedge clk);
    stall <= 1'b0;
    end_test("random stall");

    for (int i = 0; i < 8; i++) begin
      apply_redirect(($urandom % 4096) << 2);
      if (i % 2 == 0) begin
        wait_outputs(4);
      end else begin
        repeat (2 + $urandom % 3) @(posedge clk);   // Likely mid-miss
      end
    end
    wait_outputs(4);
    end_test("random redirects");

    $display("Tests run: %0d, checks: %0d, errors: %0d", test_num, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////
  initial begin
    #(EXPECTED_FETCHES * CYCLES_PER_FETCH * CLK_PERIOD_NS);
    $display("Run timed out with %0d fetches still pending", wait_target - out_count);
    $display("test failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
fetch_pkg.sv
icache_mem.sv
icache_ctrl.sv
fetch_stage.sv
fetch_top.sv
fetch_tb_clk.sv
fetch_assert.sv
fetch_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = fetch_tb
FILELIST  = vlog.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
